// File: dv/periph_fabric_asserts.sv
// Bus response checks for the peripheral fabric
// Bound into the top level, watching hreadyout and hresp
`timescale 1ns/1ps
`default_nettype none

module periph_fabric_asserts (
  input logic               clk_i,
  input logic               rst_n_i,
  input logic               hreadyout_i,
  input periph_pkg::hresp_e hresp_i
);

  import periph_pkg::*;

  // Idle default slave answers right after reset
  reset_ready_a: assert property (@(posedge clk_i) $rose(rst_n_i) |-> hreadyout_i)
    else $error("hreadyout_o low in the first cycle after reset");

  // Wait states only come with an ERROR reply
  wait_is_error_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !hreadyout_i |-> (hresp_i == ERROR))
    else $error("hreadyout_o low without an ERROR response");

  // At most one wait cycle per transfer
  single_wait_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !hreadyout_i |=> hreadyout_i)
    else $error("hreadyout_o low for two cycles in a row");

endmodule

bind periph_fabric periph_fabric_asserts i_asserts (
  .clk_i       (ahb_clk_i),
  .rst_n_i     (rst_n_i),
  .hreadyout_i (hreadyout_o),
  .hresp_i     (hresp_o)
);

`default_nettype wire

// File: dv/periph_fabric_tb.sv
// Peripheral fabric testbench
// Table-driven AHB-Lite transfers checked against the GPIO register rules
`timescale 1ns/1ps
`default_nettype none

module periph_fabric_tb;

  import periph_pkg::*;

  localparam int          RESET_CYCLES = 5;
  localparam int          NUM_XFERS    = 16;
  localparam int          MAX_CYCLES   = 4 * NUM_XFERS + RESET_CYCLES;
  localparam logic [15:0] ALT0_MASK    = 16'hFFFF;
  localparam logic [15:0] ALT1_MASK    = 16'h00FF;
  localparam logic [15:0] OUT0         = 16'hA5C3;      // DATAOUT patterns
  localparam logic [15:0] OUT1         = 16'h3C96;
  localparam logic [15:0] EN_SET       = 16'h0FF0;      // Overlapping enable patterns
  localparam logic [15:0] EN_CLR       = 16'h00FF;
  localparam ahb_addr_t   UNMAPPED     = 32'h4002_0000;

  typedef struct packed {
    logic        write;
    ahb_addr_t   addr;
    ahb_data_t   wdata;
    logic [15:0] pin0;                                  // Pins held from address phase
    logic [15:0] pin1;
    ahb_data_t   exp_rdata;
    hresp_e      exp_resp;
  } xfer_t;

  logic        clk;
  logic        rst_n;
  logic        hsel;
  logic        hready;
  htrans_e     htrans;
  logic        hwrite;
  ahb_addr_t   haddr;
  ahb_data_t   hwdata;
  logic        hreadyout;
  hresp_e      hresp;
  ahb_data_t   hrdata;
  logic [15:0] pin0;
  logic [15:0] pin1;
  logic [15:0] out0;
  logic [15:0] en0;
  logic [15:0] func0;
  logic [15:0] out1;
  logic [15:0] en1;
  logic [15:0] func1;
  xfer_t       xfers [NUM_XFERS];
  int          seed   = 32'h02a59d32;
  int          cycles = 0;

  tb_clk_gen #(.PERIOD_NS(100), .RESET_CYCLES(RESET_CYCLES)) u_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  periph_fabric #(
    .GPIO_WIDTH     (16),
    .GPIO0_ALT_MASK (ALT0_MASK),
    .GPIO1_ALT_MASK (ALT1_MASK)
  ) i_dut (
    .ahb_clk_i         (clk),
    .rst_n_i           (rst_n),
    .hsel_i            (hsel),
    .hready_i          (hready),
    .htrans_i          (htrans),
    .hwrite_i          (hwrite),
    .haddr_i           (haddr),
    .hwdata_i          (hwdata),
    .hreadyout_o       (hreadyout),
    .hresp_o           (hresp),
    .hrdata_o          (hrdata),
    .gpio0_port_in_i   (pin0),
    .gpio0_port_out_o  (out0),
    .gpio0_port_en_o   (en0),
    .gpio0_port_func_o (func0),
    .gpio1_port_in_i   (pin1),
    .gpio1_port_out_o  (out1),
    .gpio1_port_en_o   (en1),
    .gpio1_port_func_o (func1)
  );

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("TESTBENCH FAILED");
    $fatal(1, "Run stopped after a failed check");
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      stop_run($sformatf("Mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp));
    end
  endtask

  task automatic check_ports(input logic [15:0] o0, e0, f0, o1, e1, f1);
    check_value("gpio0_port_out_o", 32'(out0), 32'(o0));
    check_value("gpio0_port_en_o", 32'(en0), 32'(e0));
    check_value("gpio0_port_func_o", 32'(func0), 32'(f0));
    check_value("gpio1_port_out_o", 32'(out1), 32'(o1));
    check_value("gpio1_port_en_o", 32'(en1), 32'(e1));
    check_value("gpio1_port_func_o", 32'(func1), 32'(f1));
  endtask

  function automatic ahb_addr_t reg_addr(input ahb_addr_t base, input gpio_reg_e offs);
    return base | 32'(offs);
  endfunction

  function automatic xfer_t make_xfer(input logic wr, input ahb_addr_t addr,
                                      input ahb_data_t wdata, input ahb_data_t exp_rdata,
                                      input hresp_e exp_resp);
    return '{write: wr, addr: addr, wdata: wdata, pin0: '0, pin1: '0,
             exp_rdata: exp_rdata, exp_resp: exp_resp};
  endfunction

  // --------------------------------------------------
  // Transfer table, expected values from register rules
  // --------------------------------------------------
  task automatic build_xfers();
    int          rnd;
    logic [15:0] pa0;
    logic [15:0] pa1;
    logic [15:0] pb0;
    rnd = $random(seed);
    pa0 = rnd[15:0];
    rnd = $random(seed);
    pa1 = rnd[15:0];
    rnd = $random(seed);
    pb0 = rnd[15:0];
    xfers[0]  = make_xfer(1'b1, reg_addr(GPIO0_BASE, DATAOUT), {16'h0, OUT0}, '0, OKAY);
    xfers[1]  = make_xfer(1'b0, reg_addr(GPIO0_BASE, DATAOUT), '0, {16'h0, OUT0}, OKAY);
    xfers[2]  = make_xfer(1'b1, reg_addr(GPIO1_BASE, DATAOUT), {16'h0, OUT1}, '0, OKAY);
    xfers[3]  = make_xfer(1'b1, reg_addr(GPIO0_BASE, OUTENSET), {16'h0, EN_SET}, '0, OKAY);
    xfers[4]  = make_xfer(1'b1, reg_addr(GPIO0_BASE, OUTENCLR), {16'h0, EN_CLR}, '0, OKAY);
    xfers[5]  = make_xfer(1'b0, reg_addr(GPIO0_BASE, OUTENSET), '0,
                          {16'h0, EN_SET & ~EN_CLR}, OKAY);
    xfers[6]  = make_xfer(1'b0, reg_addr(GPIO0_BASE, OUTENCLR), '0,
                          {16'h0, EN_SET & ~EN_CLR}, OKAY);
    xfers[7]  = make_xfer(1'b1, reg_addr(GPIO0_BASE, ALTFUNCSET), 32'hFFFF_FFFF, '0, OKAY);
    xfers[8]  = make_xfer(1'b1, reg_addr(GPIO1_BASE, ALTFUNCSET), 32'hFFFF_FFFF, '0, OKAY);
    xfers[9]  = make_xfer(1'b0, reg_addr(GPIO1_BASE, ALTFUNCSET), '0, {16'h0, ALT1_MASK}, OKAY);
    xfers[10] = make_xfer(1'b0, reg_addr(GPIO0_BASE, DATA), '0, {16'h0, pa0}, OKAY);
    xfers[11] = make_xfer(1'b0, reg_addr(GPIO1_BASE, DATA), '0, {16'h0, pa1}, OKAY);
    xfers[12] = make_xfer(1'b0, UNMAPPED, '0, '0, ERROR);     // Default slave hit
    xfers[13] = make_xfer(1'b0, reg_addr(GPIO1_BASE, DATAOUT), '0, {16'h0, OUT1}, OKAY);
    xfers[14] = make_xfer(1'b0, reg_addr(GPIO0_BASE, ALTFUNCCLR), '0, {16'h0, ALT0_MASK}, OKAY);
    xfers[15] = make_xfer(1'b0, reg_addr(GPIO0_BASE, DATA), '0, {16'h0, pb0}, OKAY);
    for (int i = 0; i < NUM_XFERS; i++) begin
      xfers[i].pin0 = (i < 13) ? pa0 : pb0;             // New pins two entries before read
      xfers[i].pin1 = pa1;
    end
  endtask

  // Run limit
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      stop_run($sformatf("Timeout: table not finished after %0d cycles", cycles));
    end
  end

  // --------------------------------------------------
  // Stimulus and checks
  // --------------------------------------------------
  initial begin
    int waits;
    hsel   <= 1'b0;
    hready <= 1'b1;                                     // Master waits by going idle
    htrans <= IDLE;
    hwrite <= 1'b0;
    haddr  <= '0;
    hwdata <= '0;
    pin0   <= '0;
    pin1   <= '0;
    build_xfers();
    @(posedge rst_n);
    @(negedge clk);
    check_value("hreadyout_o", 32'(hreadyout), 32'h1);
    check_value("hresp_o", 32'(hresp), 32'(OKAY));
    check_ports('0, '0, '0, '0, '0, '0);
    @(posedge clk);
    for (int i = 0; i < NUM_XFERS; i++) begin
      hsel   <= 1'b1;                                   // Address phase
      htrans <= NONSEQ;
      hwrite <= xfers[i].write;
      haddr  <= xfers[i].addr;
      pin0   <= xfers[i].pin0;
      pin1   <= xfers[i].pin1;
      @(posedge clk);
      hsel   <= 1'b0;                                   // Data phase, bus idle
      htrans <= IDLE;
      hwdata <= xfers[i].wdata;
      waits = 0;
      @(negedge clk);
      while (!hreadyout) begin
        check_value("hresp_o", 32'(hresp), 32'(ERROR));
        waits++;
        @(negedge clk);
      end
      assert (waits == ((xfers[i].exp_resp == ERROR) ? 1 : 0)) else begin
        stop_run($sformatf("Transfer %0d ended after a wrong number of wait cycles (%0d)",
                           i, waits));
      end
      check_value("hresp_o", 32'(hresp), 32'(xfers[i].exp_resp));
      if (!xfers[i].write) begin
        check_value("hrdata_o", hrdata, xfers[i].exp_rdata);
      end
      @(posedge clk);
    end
    @(negedge clk);
    check_ports(OUT0, EN_SET & ~EN_CLR, ALT0_MASK, OUT1, '0, ALT1_MASK);
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: dv/tb_clk_gen.sv
// Testbench clock and reset source
// Free-running clock, active-low reset held for a few cycles
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD_NS    = 100,     // Clock period
  parameter int RESET_CYCLES = 5        // Cycles in reset
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  initial begin
    rst_n_o <= 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_n_o <= 1'b1;                    // Released on an edge
  end

endmodule

`default_nettype wire

// File: periph_fabric.f
source/periph_pkg.sv
source/ahb_decode_mux.sv
source/ahb_default_slave.sv
source/ahb_gpio.sv
source/periph_fabric.sv
dv/tb_clk_gen.sv
dv/periph_fabric_asserts.sv
dv/periph_fabric_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the peripheral fabric testbench with Verilator
verilator --binary --timing --assert -j 0 --top-module periph_fabric_tb \
  -f periph_fabric.f -Mdir obj_dir -o periph_fabric_sim > build.log 2>&1 &&
  ./obj_dir/periph_fabric_sim > sim.log 2>&1 &&
  grep -q "TESTBENCH PASSED" sim.log &&
  echo "Simulation run OK" ||
  { echo "Simulation run failed, see build.log and sim.log"; exit 1; }

// File: source/ahb_decode_mux.sv
// AHB-Lite address decoder and response multiplexer
// One-hot slave selects in the address phase, reply steering in the data phase
`timescale 1ns/1ps
`default_nettype none

module ahb_decode_mux (
  input  logic                                          ahb_clk_i,
  input  logic                                          rst_n_i,
  input  periph_pkg::ahb_req_t                          req_i,      // Master request
  output logic [periph_pkg::NUM_SLAVES-1:0]             hsel_o,     // Per-slave select
  input  periph_pkg::ahb_rsp_t [periph_pkg::NUM_SLAVES-1:0] slv_rsp_i,  // Slave replies
  output periph_pkg::ahb_rsp_t                          rsp_o       // Reply to master
);

  import periph_pkg::*;

  localparam int REGION_W = 32 - DECODE_LSB;     // Compared upper bits

  logic [REGION_W-1:0] region;                   // Address region of current request
  slave_e              slv_dec;                  // Address-phase decode
  slave_e              slv_q;                    // Owner of the data phase

  // --------------------------------------------------
  // Address phase decode
  // --------------------------------------------------
  assign region = req_i.addr[31:DECODE_LSB];

  always_comb begin
    if (region == GPIO0_BASE[31:DECODE_LSB]) begin
      slv_dec = SLV_GPIO0;
    end else if (region == GPIO1_BASE[31:DECODE_LSB]) begin
      slv_dec = SLV_GPIO1;
    end else begin
      slv_dec = SLV_DEFAULT;                     // Everything else is unmapped
    end
  end

  // One select bit per slave, only while the cluster is selected
  always_comb begin
    for (int i = 0; i < NUM_SLAVES; i++) begin
      hsel_o[i] = req_i.sel && (slv_dec == slave_e'(i));
    end
  end

  // --------------------------------------------------
  // Data phase ownership
  // --------------------------------------------------
  // Updated only when the previous data phase completes
  always_ff @(posedge ahb_clk_i) begin
    if (!rst_n_i) begin
      slv_q <= SLV_DEFAULT;                      // Idle default slave answers OKAY
    end else if (req_i.ready) begin
      if (req_i.sel) begin
        slv_q <= slv_dec;
      end else begin
        slv_q <= SLV_DEFAULT;                    // Not ours, park on default
      end
    end
  end

  // Reply from the slave owning the data phase
  assign rsp_o = slv_rsp_i[slv_q];

endmodule

`default_nettype wire

// File: source/ahb_default_slave.sv
// AHB-Lite default slave
// Two-cycle ERROR reply for active transfers to unmapped space
`timescale 1ns/1ps
`default_nettype none

module ahb_default_slave (
  input  logic                 ahb_clk_i,
  input  logic                 rst_n_i,
  input  periph_pkg::ahb_req_t req_i,           // Master request
  input  logic                 hsel_i,          // Unmapped region hit
  output periph_pkg::ahb_rsp_t rsp_o            // Reply to mux
);

  import periph_pkg::*;

  typedef enum logic {
    DS_IDLE,                                    // Zero-wait OKAY
    DS_ERR_WAIT                                 // First ERROR cycle
  } ds_state_e;

  ds_state_e state_q, state_d;
  logic      err_q;                             // Second ERROR cycle
  logic      accept;                            // Active transfer taken

  assign accept = hsel_i && req_i.ready && (req_i.trans inside {NONSEQ, SEQ});

  always_comb begin
    state_d = state_q;
    case (state_q)
      DS_IDLE:     if (accept) state_d = DS_ERR_WAIT;
      DS_ERR_WAIT: state_d = DS_IDLE;           // Always one wait cycle
      default:     state_d = DS_IDLE;
    endcase
  end

  always_ff @(posedge ahb_clk_i) begin
    if (!rst_n_i) begin
      state_q <= DS_IDLE;
      err_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      err_q   <= (state_q == DS_ERR_WAIT);      // Completing cycle follows the wait
    end
  end

  // ERROR held over both cycles, data always zero
  assign rsp_o = '{readyout: (state_q != DS_ERR_WAIT),
                   resp:     ((state_q == DS_ERR_WAIT) || err_q) ? ERROR : OKAY,
                   rdata:    '0};

endmodule

`default_nettype wire

// File: source/ahb_gpio.sv
// AHB-Lite GPIO block
// Output data, output-enable and alternate-function registers with pin readback
`timescale 1ns/1ps
`default_nettype none

module ahb_gpio #(
  parameter int                    GPIO_WIDTH    = 16,    // Pin count
  parameter logic [GPIO_WIDTH-1:0] ALT_FUNC_MASK = '1     // Pins with an alternate function
) (
  input  logic                  ahb_clk_i,
  input  logic                  rst_n_i,
  input  periph_pkg::ahb_req_t  req_i,          // Master request
  input  logic                  hsel_i,         // Region hit from decoder
  input  logic [GPIO_WIDTH-1:0] port_in_i,      // Asynchronous pins
  output periph_pkg::ahb_rsp_t  rsp_o,          // Reply to mux
  output logic [GPIO_WIDTH-1:0] port_out_o,     // Output data
  output logic [GPIO_WIDTH-1:0] port_en_o,      // Output enable
  output logic [GPIO_WIDTH-1:0] port_func_o     // Alternate function select
);

  import periph_pkg::*;

  localparam logic [7:0] OFFS_NONE = 8'hFF;     // Not a register, reads zero

  logic                  accept;                // Active transfer taken
  logic                  wr_q;                  // Write data phase
  logic [7:0]            offs_q;                // Word offset of data phase
  logic [GPIO_WIDTH-1:0] wdata;
  logic [GPIO_WIDTH-1:0] dout_q;
  logic [GPIO_WIDTH-1:0] outen_q;
  logic [GPIO_WIDTH-1:0] altf_q;
  logic [GPIO_WIDTH-1:0] pin_meta_q;            // First sync stage
  logic [GPIO_WIDTH-1:0] pin_sync_q;            // Second sync stage
  logic [GPIO_WIDTH-1:0] rd_word;

  // --------------------------------------------------
  // Address phase capture
  // --------------------------------------------------
  assign accept = hsel_i && req_i.ready && (req_i.trans inside {NONSEQ, SEQ});
  assign wdata  = req_i.wdata[GPIO_WIDTH-1:0];  // Full-word writes only

  always_ff @(posedge ahb_clk_i) begin
    if (!rst_n_i) begin
      wr_q <= 1'b0;
    end else if (req_i.ready) begin
      wr_q <= accept && req_i.write;            // Cleared when the data phase ends
    end
  end

  // Offsets above the first page are unmapped
  always_ff @(posedge ahb_clk_i) begin
    if (accept) begin
      if (req_i.addr[DECODE_LSB-1:8] == '0) begin
        offs_q <= req_i.addr[7:0];
      end else begin
        offs_q <= OFFS_NONE;
      end
    end
  end

  // --------------------------------------------------
  // Registers, written at end of data phase
  // --------------------------------------------------
  always_ff @(posedge ahb_clk_i) begin
    if (!rst_n_i) begin
      dout_q  <= '0;
      outen_q <= '0;
      altf_q  <= '0;
    end else if (wr_q && req_i.ready) begin
      case (offs_q)
        DATA, DATAOUT: dout_q  <= wdata;
        OUTENSET:      outen_q <= outen_q | wdata;
        OUTENCLR:      outen_q <= outen_q & ~wdata;
        ALTFUNCSET:    altf_q  <= (altf_q | wdata) & ALT_FUNC_MASK;  // Masked pins stay 0
        ALTFUNCCLR:    altf_q  <= altf_q & ~wdata;
        default:       ;                        // Unmapped writes dropped
      endcase
    end
  end

  // Two-flop pin synchronizer
  always_ff @(posedge ahb_clk_i) begin
    pin_meta_q <= port_in_i;
    pin_sync_q <= pin_meta_q;
  end

  // --------------------------------------------------
  // Read data, from current register state
  // --------------------------------------------------
  always_comb begin
    rd_word = '0;
    case (offs_q)
      DATA:                 rd_word = pin_sync_q;
      DATAOUT:              rd_word = dout_q;
      OUTENSET, OUTENCLR:   rd_word = outen_q;  // Pair shares one register
      ALTFUNCSET, ALTFUNCCLR: rd_word = altf_q;
      default:              rd_word = '0;
    endcase
  end

  // Zero-wait OKAY for every access
  assign rsp_o = '{readyout: 1'b1,
                   resp:     OKAY,
                   rdata:    ahb_data_t'(rd_word)};

  assign port_out_o  = dout_q;
  assign port_en_o   = outen_q;
  assign port_func_o = altf_q;

endmodule

`default_nettype wire

// File: source/periph_fabric.sv
// AHB-Lite peripheral fabric top level
// Decoder-mux, default slave and two GPIO blocks on one clock
`timescale 1ns/1ps
`default_nettype none

module periph_fabric #(
  parameter int                    GPIO_WIDTH     = 16,       // Pins per GPIO
  parameter logic [GPIO_WIDTH-1:0] GPIO0_ALT_MASK = 16'hFFFF, // All pins alternate
  parameter logic [GPIO_WIDTH-1:0] GPIO1_ALT_MASK = 16'h00FF  // Low byte alternate
) (
  input  logic                    ahb_clk_i,
  input  logic                    rst_n_i,
  // AHB master side
  input  logic                    hsel_i,
  input  logic                    hready_i,
  input  periph_pkg::htrans_e     htrans_i,
  input  logic                    hwrite_i,
  input  periph_pkg::ahb_addr_t   haddr_i,
  input  periph_pkg::ahb_data_t   hwdata_i,
  output logic                    hreadyout_o,
  output periph_pkg::hresp_e      hresp_o,
  output periph_pkg::ahb_data_t   hrdata_o,
  // GPIO0 pins
  input  logic [GPIO_WIDTH-1:0]   gpio0_port_in_i,
  output logic [GPIO_WIDTH-1:0]   gpio0_port_out_o,
  output logic [GPIO_WIDTH-1:0]   gpio0_port_en_o,
  output logic [GPIO_WIDTH-1:0]   gpio0_port_func_o,
  // GPIO1 pins
  input  logic [GPIO_WIDTH-1:0]   gpio1_port_in_i,
  output logic [GPIO_WIDTH-1:0]   gpio1_port_out_o,
  output logic [GPIO_WIDTH-1:0]   gpio1_port_en_o,
  output logic [GPIO_WIDTH-1:0]   gpio1_port_func_o
);

  import periph_pkg::*;

  ahb_req_t                   req;              // Fans out to every block
  ahb_rsp_t                   rsp;              // Muxed reply
  ahb_rsp_t [NUM_SLAVES-1:0]  slv_rsp;          // One reply per mux port
  logic     [NUM_SLAVES-1:0]  hsel;             // One-hot slave selects

  assign req = '{sel: hsel_i, ready: hready_i, trans: htrans_i,
                 write: hwrite_i, addr: haddr_i, wdata: hwdata_i};

  assign hreadyout_o = rsp.readyout;
  assign hresp_o     = rsp.resp;
  assign hrdata_o    = rsp.rdata;

  // --------------------------------------------------
  // Decoder, mux and default slave
  // --------------------------------------------------
  ahb_decode_mux u_decode_mux (
    .ahb_clk_i (ahb_clk_i),
    .rst_n_i   (rst_n_i),
    .req_i     (req),
    .hsel_o    (hsel),
    .slv_rsp_i (slv_rsp),
    .rsp_o     (rsp)
  );

  ahb_default_slave u_default_slave (
    .ahb_clk_i (ahb_clk_i),
    .rst_n_i   (rst_n_i),
    .req_i     (req),
    .hsel_i    (hsel[SLV_DEFAULT]),
    .rsp_o     (slv_rsp[SLV_DEFAULT])
  );

  // --------------------------------------------------
  // GPIO blocks
  // --------------------------------------------------
  ahb_gpio #(
    .GPIO_WIDTH    (GPIO_WIDTH),
    .ALT_FUNC_MASK (GPIO0_ALT_MASK)
  ) u_gpio_0 (
    .ahb_clk_i   (ahb_clk_i),
    .rst_n_i     (rst_n_i),
    .req_i       (req),
    .hsel_i      (hsel[SLV_GPIO0]),
    .port_in_i   (gpio0_port_in_i),
    .rsp_o       (slv_rsp[SLV_GPIO0]),
    .port_out_o  (gpio0_port_out_o),
    .port_en_o   (gpio0_port_en_o),
    .port_func_o (gpio0_port_func_o)
  );

  ahb_gpio #(
    .GPIO_WIDTH    (GPIO_WIDTH),
    .ALT_FUNC_MASK (GPIO1_ALT_MASK)
  ) u_gpio_1 (
    .ahb_clk_i   (ahb_clk_i),
    .rst_n_i     (rst_n_i),
    .req_i       (req),
    .hsel_i      (hsel[SLV_GPIO1]),
    .port_in_i   (gpio1_port_in_i),
    .rsp_o       (slv_rsp[SLV_GPIO1]),
    .port_out_o  (gpio1_port_out_o),
    .port_en_o   (gpio1_port_en_o),
    .port_func_o (gpio1_port_func_o)
  );

endmodule

`default_nettype wire

// File: source/periph_pkg.sv
// Peripheral fabric shared definitions
// AHB-Lite bus types, slave map and GPIO register offsets
`default_nettype none

package periph_pkg;

  // --------------------------------------------------
  // AHB-Lite bus types
  // --------------------------------------------------
  typedef logic [31:0] ahb_data_t;                // Bus data word
  typedef logic [31:0] ahb_addr_t;                // Bus address

  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,                               // First beat of a burst
    SEQ    = 2'b11
  } htrans_e;

  typedef enum logic {
    OKAY  = 1'b0,
    ERROR = 1'b1
  } hresp_e;

  // Master request, shared by decoder and all slaves
  typedef struct packed {
    logic      sel;                               // HSEL of the cluster
    logic      ready;                             // HREADY in
    htrans_e   trans;
    logic      write;
    ahb_addr_t addr;
    ahb_data_t wdata;
  } ahb_req_t;

  // One slave's reply
  typedef struct packed {
    logic      readyout;
    hresp_e    resp;
    ahb_data_t rdata;
  } ahb_rsp_t;

  // --------------------------------------------------
  // Address map
  // --------------------------------------------------
  typedef enum logic [1:0] {
    SLV_DEFAULT = 2'd0,                           // Unmapped space
    SLV_GPIO0   = 2'd1,
    SLV_GPIO1   = 2'd2
  } slave_e;

  localparam int        NUM_SLAVES = 3;
  localparam int        DECODE_LSB = 10;          // 1 KiB regions
  localparam ahb_addr_t GPIO0_BASE = 32'h4001_0000;
  localparam ahb_addr_t GPIO1_BASE = 32'h4001_1000;

  // GPIO word offsets
  typedef enum logic [7:0] {
    DATA       = 8'h00,                           // Pins on read, output data on write
    DATAOUT    = 8'h04,
    OUTENSET   = 8'h10,
    OUTENCLR   = 8'h14,
    ALTFUNCSET = 8'h18,
    ALTFUNCCLR = 8'h1C
  } gpio_reg_e;

endpackage

`default_nettype wire
